//--- hdl/mem_sched_defs.svh
`ifndef MEM_SCHED_DEFS_SVH
`define MEM_SCHED_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// sizes
////////////////////////////////////////////////////////////////////////////

// one queue per core
`define MS_NUM_QUEUES 4
// entries held by each queue
`define MS_QUEUE_DEPTH 8
// request address width
`define MS_ADDR_W 32
// cycle counter, relative and absolute deadlines
`define MS_TIME_W 32

////////////////////////////////////////////////////////////////////////////
// apb register map, byte offsets
////////////////////////////////////////////////////////////////////////////

`define MS_REG_MODE 8'h00
`define MS_REG_SLOT 8'h04
// one word per queue, 4 bytes apart
`define MS_REG_DL_BASE 8'h10
`define MS_REG_PRIO_BASE 8'h20

`endif

//--- hdl/mem_sched_pkg.sv
`include "mem_sched_defs.svh"

package mem_sched_pkg;

    // scheduling policy, value 3 is reserved
    typedef enum logic [1:0] {
        POLICY_FP   = 2'd0,
        POLICY_EDF  = 2'd1,
        POLICY_TDMA = 2'd2
    } sched_policy_e;

    // queue / core index
    typedef logic [$clog2(`MS_NUM_QUEUES)-1:0] core_id_t;

    // request as seen on ingress and egress
    typedef struct packed {
        core_id_t               core_id;
        logic                   is_write;
        logic [`MS_ADDR_W-1:0]  addr;
    } mem_req_t;

    // queued request, stamped on acceptance
    typedef struct packed {
        mem_req_t               req;
        logic [`MS_TIME_W-1:0]  abs_deadline;
    } queue_entry_t;

    // apb requester side
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // apb completer side
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // live configuration seen by the scheduler
    typedef struct packed {
        sched_policy_e                                policy;
        logic [15:0]                                  slot_len;
        logic [`MS_NUM_QUEUES-1:0][`MS_TIME_W-1:0]    rel_deadline;
        logic [`MS_NUM_QUEUES-1:0][3:0]               prio;
    } sched_cfg_t;

endpackage

//--- hdl/sched_config_regs.sv
`include "mem_sched_defs.svh"

module sched_config_regs (
    input  logic                    aclk,
    input  logic                    arst_n,
    input  mem_sched_pkg::apb_req_t apb,
    output mem_sched_pkg::apb_rsp_t apb_rsp,
    output mem_sched_pkg::sched_cfg_t cfg
);
    import mem_sched_pkg::*;

    localparam int N = `MS_NUM_QUEUES;

    sched_cfg_t   cfg_q;
    logic         access;
    logic         hit;
    logic         mode_err;
    logic         wr_en;
    logic         sel_mode;
    logic         sel_slot;
    logic [N-1:0] sel_dl;
    logic [N-1:0] sel_prio;
    logic [31:0]  rd_data;

    ////////////////////////////////////////////////////////////////////////////
    // address decode and read mux
    ////////////////////////////////////////////////////////////////////////////

    // access phase, zero wait states
    assign access = apb.psel && apb.penable;

    always_comb begin
        sel_mode = (apb.paddr == `MS_REG_MODE);
        sel_slot = (apb.paddr == `MS_REG_SLOT);
        rd_data  = '0;
        if (sel_mode) begin
            rd_data = 32'(cfg_q.policy);
        end
        if (sel_slot) begin
            rd_data = 32'(cfg_q.slot_len);
        end
        for (int i = 0; i < N; i++) begin
            sel_dl[i]   = (apb.paddr == `MS_REG_DL_BASE + 8'(4 * i));
            sel_prio[i] = (apb.paddr == `MS_REG_PRIO_BASE + 8'(4 * i));
            if (sel_dl[i]) begin
                rd_data = 32'(cfg_q.rel_deadline[i]);
            end
            if (sel_prio[i]) begin
                rd_data = 32'(cfg_q.prio[i]);
            end
        end
        hit = sel_mode || sel_slot || (|sel_dl) || (|sel_prio);
    end

    // reserved policy code is refused
    assign mode_err = sel_mode && apb.pwrite && (apb.pwdata[1:0] == 2'd3);
    assign wr_en    = access && apb.pwrite && hit && !mode_err;

    assign apb_rsp.prdata  = rd_data;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && (!hit || mode_err);

    ////////////////////////////////////////////////////////////////////////////
    // register file
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_q.policy   <= POLICY_FP;
            cfg_q.slot_len <= 16'd1;
            for (int i = 0; i < N; i++) begin
                cfg_q.rel_deadline[i] <= '0;
                // default priority follows the queue index
                cfg_q.prio[i]         <= 4'(i);
            end
        end else if (wr_en) begin
            if (sel_mode) begin
                cfg_q.policy <= sched_policy_e'(apb.pwdata[1:0]);
            end
            if (sel_slot) begin
                cfg_q.slot_len <= apb.pwdata[15:0];
            end
            for (int i = 0; i < N; i++) begin
                if (sel_dl[i]) begin
                    cfg_q.rel_deadline[i] <= apb.pwdata[`MS_TIME_W-1:0];
                end
                if (sel_prio[i]) begin
                    cfg_q.prio[i] <= apb.pwdata[3:0];
                end
            end
        end
    end

    assign cfg = cfg_q;

    // policy register never holds the reserved code
    a_policy_legal: assert property (@(posedge aclk) disable iff (!arst_n)
        cfg_q.policy inside {POLICY_FP, POLICY_EDF, POLICY_TDMA});

endmodule

//--- hdl/request_queue.sv
`include "mem_sched_defs.svh"

module request_queue (
    input  logic                        aclk,
    input  logic                        arst_n,
    input  logic                        push,
    input  logic                        pop,
    input  mem_sched_pkg::queue_entry_t wr_entry,
    output mem_sched_pkg::queue_entry_t head,
    output logic                        empty,
    output logic                        full
);
    import mem_sched_pkg::*;

    localparam int DEPTH = `MS_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    // storage, no reset
    queue_entry_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // occupancy, one extra bit for the full state
    logic [PTR_W:0]   count;

    assign empty = (count == '0);
    assign full  = (count == (PTR_W + 1)'(DEPTH));
    // head shows the oldest entry
    assign head  = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pointers and count
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // ingress must hold off a full queue
    a_no_overflow: assert property (@(posedge aclk) disable iff (!arst_n)
        push |-> !full);
    // selector only grants queues with entries
    a_no_underflow: assert property (@(posedge aclk) disable iff (!arst_n)
        pop |-> !empty);

endmodule

//--- hdl/queue_selector.sv
`include "mem_sched_defs.svh"

module queue_selector (
    input  logic                                        aclk,
    input  logic                                        arst_n,
    input  mem_sched_pkg::sched_cfg_t                   cfg,
    input  logic [`MS_NUM_QUEUES-1:0]                   nonempty,
    input  logic [`MS_NUM_QUEUES-1:0][`MS_TIME_W-1:0]   head_deadlines,
    input  logic                                        advance,
    output mem_sched_pkg::core_id_t                     grant,
    output logic                                        grant_valid
);
    import mem_sched_pkg::*;

    localparam int N      = `MS_NUM_QUEUES;
    localparam int TIME_W = `MS_TIME_W;

    logic [N-1:0][TIME_W-1:0] prio_keys;
    core_id_t                 fp_grant;
    core_id_t                 edf_grant;
    logic                     any_pending;

    // tdma slot state
    core_id_t                 owner;
    core_id_t                 owner_next;
    logic [15:0]              slot_cnt;
    logic [16:0]              slot_cnt_inc;
    logic                     slot_done;
    logic                     owner_busy;

    ////////////////////////////////////////////////////////////////////////////
    // fixed priority and edf
    ////////////////////////////////////////////////////////////////////////////

    // smallest key among valid queues
    // strict compare so a tie keeps the lower index
    function automatic core_id_t pick_min(input logic [N-1:0] valid,
                                          input logic [N-1:0][TIME_W-1:0] keys);
        core_id_t          idx;
        logic [TIME_W-1:0] best;
        logic              found;
        idx   = '0;
        best  = '1;
        found = 1'b0;
        for (int i = 0; i < N; i++) begin
            if (valid[i] && (!found || keys[i] < best)) begin
                idx   = core_id_t'(i);
                best  = keys[i];
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    // priorities widened to share the comparator
    always_comb begin
        for (int i = 0; i < N; i++) begin
            prio_keys[i] = TIME_W'(cfg.prio[i]);
        end
    end

    assign fp_grant    = pick_min(nonempty, prio_keys);
    assign edf_grant   = pick_min(nonempty, head_deadlines);
    assign any_pending = |nonempty;

    ////////////////////////////////////////////////////////////////////////////
    // tdma slot timer
    ////////////////////////////////////////////////////////////////////////////

    assign owner_next   = (owner == core_id_t'(N - 1)) ? '0 : owner + 1'b1;
    assign owner_busy   = nonempty[owner];
    // slot_len of 0 acts as 1
    assign slot_cnt_inc = {1'b0, slot_cnt} + 17'd1;
    assign slot_done    = (slot_cnt_inc >= {1'b0, cfg.slot_len});

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            owner    <= '0;
            slot_cnt <= '0;
        end else if (cfg.policy != POLICY_TDMA) begin
            // restart from queue 0 when tdma is entered
            owner    <= '0;
            slot_cnt <= '0;
        end else if (!owner_busy) begin
            // idle owner gives up the rest of its slot
            owner    <= owner_next;
            slot_cnt <= '0;
        end else if (advance) begin
            // stalled cycles do not count against the slot
            if (slot_done) begin
                owner    <= owner_next;
                slot_cnt <= '0;
            end else begin
                slot_cnt <= slot_cnt_inc[15:0];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // policy mux
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        grant       = '0;
        grant_valid = 1'b0;
        case (cfg.policy)
            POLICY_FP: begin
                grant       = fp_grant;
                grant_valid = any_pending;
            end
            POLICY_EDF: begin
                grant       = edf_grant;
                grant_valid = any_pending;
            end
            POLICY_TDMA: begin
                // only the slot owner may go
                grant       = owner;
                grant_valid = owner_busy;
            end
            default: begin
                grant       = '0;
                grant_valid = 1'b0;
            end
        endcase
    end

endmodule

//--- hdl/mem_sched_top.sv
`include "mem_sched_defs.svh"

module mem_sched_top (
    input  logic                      aclk,
    input  logic                      arst_n,
    input  logic                      req_valid,
    input  mem_sched_pkg::mem_req_t   req,
    output logic                      req_ready,
    output logic                      out_valid,
    output mem_sched_pkg::mem_req_t   out,
    input  logic                      out_ready,
    input  mem_sched_pkg::apb_req_t   apb,
    output mem_sched_pkg::apb_rsp_t   apb_rsp
);
    import mem_sched_pkg::*;

    localparam int N      = `MS_NUM_QUEUES;
    localparam int TIME_W = `MS_TIME_W;

    sched_cfg_t               cfg;
    logic [TIME_W-1:0]        cycle_cnt;
    queue_entry_t             in_entry;
    logic [N-1:0]             q_push;
    logic [N-1:0]             q_pop;
    logic [N-1:0]             q_empty;
    logic [N-1:0]             q_full;
    queue_entry_t [N-1:0]     q_head;
    logic [N-1:0][TIME_W-1:0] head_deadlines;
    core_id_t                 grant;
    logic                     grant_valid;
    logic                     load_ok;
    logic                     take;
    logic                     out_valid_q;
    mem_req_t                 out_q;

    sched_config_regs u_config (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .apb     (apb),
        .apb_rsp (apb_rsp),
        .cfg     (cfg)
    );

    ////////////////////////////////////////////////////////////////////////////
    // ingress steering and deadline stamping
    ////////////////////////////////////////////////////////////////////////////

    // free-running time base, 0 on the first cycle out of reset
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // stall only the core whose queue is full
    assign req_ready             = !q_full[req.core_id];
    assign in_entry.req          = req;
    assign in_entry.abs_deadline = cycle_cnt + cfg.rel_deadline[req.core_id];

    // output register is free or drains this cycle
    assign load_ok = !out_valid_q || out_ready;
    assign take    = grant_valid && load_ok;

    for (genvar g = 0; g < N; g++) begin : g_queue
        assign q_push[g]         = req_valid && req_ready && (req.core_id == core_id_t'(g));
        assign q_pop[g]          = take && (grant == core_id_t'(g));
        assign head_deadlines[g] = q_head[g].abs_deadline;

        request_queue u_queue (
            .aclk     (aclk),
            .arst_n   (arst_n),
            .push     (q_push[g]),
            .pop      (q_pop[g]),
            .wr_entry (in_entry),
            .head     (q_head[g]),
            .empty    (q_empty[g]),
            .full     (q_full[g])
        );
    end

    queue_selector u_selector (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .cfg            (cfg),
        .nonempty       (~q_empty),
        .head_deadlines (head_deadlines),
        .advance        (take),
        .grant          (grant),
        .grant_valid    (grant_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // egress register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid_q <= 1'b0;
        end else if (load_ok) begin
            out_valid_q <= grant_valid;
        end
    end

    // payload follows the granted head
    always_ff @(posedge aclk) begin
        if (take) begin
            out_q <= q_head[grant].req;
        end
    end

    assign out_valid = out_valid_q;
    assign out       = out_q;

    // stalled output holds until the handshake
    a_out_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out));

endmodule

//--- verif/mem_sched_tb.sv
`include "mem_sched_defs.svh"

module mem_sched_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mem_sched_pkg::*;

    localparam int NQ            = `MS_NUM_QUEUES;
    localparam int DEPTH         = `MS_QUEUE_DEPTH;
    localparam int RESET_CYCLES  = 16;
    localparam int PUSH_TIMEOUT  = 300;
    localparam int DRAIN_TIMEOUT = 600;
    // per-test cycle budgets, summed by the watchdog
    localparam int BUDGET_REGS   = 400;
    localparam int BUDGET_FP     = 300;
    localparam int BUDGET_EDF    = 300;
    localparam int BUDGET_TDMA   = 400;
    localparam int BUDGET_BP     = 1500;
    localparam int BUDGET_MARGIN = 200;

    logic     aclk;
    logic     arst_n;
    logic     req_valid;
    mem_req_t req;
    logic     req_ready;
    logic     out_valid;
    mem_req_t out;
    logic     out_ready;
    apb_req_t apb;
    apb_rsp_t apb_rsp;

    // configuration as the testbench expects it
    sched_policy_e m_policy;
    logic [15:0]   m_slot;
    logic [31:0]   m_dl [NQ];
    logic [3:0]    m_prio [NQ];

    // cycle model of the queues and the output register
    mem_req_t      mq_req [NQ][$];
    logic [31:0]   mq_dl [NQ][$];
    logic          m_ov;
    mem_req_t      m_out;
    // everything accepted and not yet seen on out, per core
    mem_req_t      sent [NQ][$];

    logic [31:0]   tb_cycle;
    logic          prev_stall;
    mem_req_t      prev_out;
    int            ready_mode;
    // ingress was held off by a full queue
    logic          saw_full;
    int            error_count;
    int            test_start_errors;
    int            pass_count;
    int            fail_count;

    mem_sched_top uut (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .out_valid (out_valid),
        .out       (out),
        .out_ready (out_ready),
        .apb       (apb),
        .apb_rsp   (apb_rsp)
    );

    always #10 aclk = ~aclk;

    ////////////////////////////////////////////////////////////////////////////
    // reporting and reference functions
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string sig, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("FAILED %0t %s expected %h actual %h", $time, sig, exp, act);
        error_count++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        error_count++;
    endtask

    function automatic bit reg_known(input logic [7:0] addr);
        if (addr == `MS_REG_MODE || addr == `MS_REG_SLOT) return 1'b1;
        for (int i = 0; i < NQ; i++) begin
            if (addr == `MS_REG_DL_BASE + 8'(4 * i)) return 1'b1;
            if (addr == `MS_REG_PRIO_BASE + 8'(4 * i)) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] expected_reg(input logic [7:0] addr);
        if (addr == `MS_REG_MODE) return 32'(m_policy);
        if (addr == `MS_REG_SLOT) return 32'(m_slot);
        for (int i = 0; i < NQ; i++) begin
            if (addr == `MS_REG_DL_BASE + 8'(4 * i)) return m_dl[i];
            if (addr == `MS_REG_PRIO_BASE + 8'(4 * i)) return 32'(m_prio[i]);
        end
        return '0;
    endfunction

    // smallest priority number wins, ties to the lower core
    function automatic int predict_fp();
        int best;
        best = -1;
        for (int i = 0; i < NQ; i++) begin
            if (mq_req[i].size() != 0 && (best < 0 || m_prio[i] < m_prio[best])) best = i;
        end
        return best;
    endfunction

    // earliest head deadline wins, ties to the lower core
    function automatic int predict_edf();
        int best;
        best = -1;
        for (int i = 0; i < NQ; i++) begin
            if (mq_req[i].size() != 0 && (best < 0 || mq_dl[i][0] < mq_dl[best][0])) best = i;
        end
        return best;
    endfunction

    function automatic int pending_count();
        int total;
        total = 0;
        for (int i = 0; i < NQ; i++) total += sent[i].size();
        return total;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // apb and ingress tasks
    ////////////////////////////////////////////////////////////////////////////

    // setup then access phase, response sampled at the closing edge
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = wr;
        apb.paddr   = addr;
        apb.pwdata  = wdata;
        @(posedge aclk);
        #2;
        apb.penable = 1'b1;
        @(posedge aclk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        if (apb_rsp.pready !== 1'b1) report_error("pready was low in the access phase");
        #2;
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        logic        err_exp;
        err_exp = !reg_known(addr) || (addr == `MS_REG_MODE && data[1:0] == 2'd3);
        apb_xfer(1'b1, addr, data, rdata, err);
        if (err !== err_exp) report_mismatch("pslverr", 64'(err_exp), 64'(err));
        // refused writes leave the model alone
        if (!err_exp) begin
            if (addr == `MS_REG_MODE) m_policy = sched_policy_e'(data[1:0]);
            if (addr == `MS_REG_SLOT) m_slot = data[15:0];
            for (int i = 0; i < NQ; i++) begin
                if (addr == `MS_REG_DL_BASE + 8'(4 * i)) m_dl[i] = data;
                if (addr == `MS_REG_PRIO_BASE + 8'(4 * i)) m_prio[i] = data[3:0];
            end
        end
    endtask

    task automatic apb_read(input logic [7:0] addr);
        logic [31:0] rdata;
        logic        err;
        logic        err_exp;
        err_exp = !reg_known(addr);
        apb_xfer(1'b0, addr, '0, rdata, err);
        if (err !== err_exp) report_mismatch("pslverr", 64'(err_exp), 64'(err));
        if (!err_exp && rdata !== expected_reg(addr)) begin
            report_mismatch("prdata", 64'(expected_reg(addr)), 64'(rdata));
        end
    endtask

    task automatic read_all_regs();
        apb_read(`MS_REG_MODE);
        apb_read(`MS_REG_SLOT);
        for (int i = 0; i < NQ; i++) begin
            apb_read(`MS_REG_DL_BASE + 8'(4 * i));
            apb_read(`MS_REG_PRIO_BASE + 8'(4 * i));
        end
    endtask

    // hold valid until the queue takes it
    task automatic push_req(input mem_req_t r);
        int waited;
        waited    = 0;
        req       = r;
        req_valid = 1'b1;
        @(negedge aclk);
        while (!req_ready && waited < PUSH_TIMEOUT) begin
            waited++;
            @(negedge aclk);
        end
        if (!req_ready) report_error("request was not accepted before the timeout");
        @(posedge aclk);
        #2;
        req_valid = 1'b0;
    endtask

    // cap keeps each core below a full queue, bias favours core 0
    task automatic fill_queues(input int count, input bit cap, input bit bias);
        mem_req_t r;
        int       c;
        for (int n = 0; n < count; n++) begin
            c = (bias && $urandom % 2 == 0) ? 0 : int'($urandom % NQ);
            while (cap && sent[c].size() >= DEPTH) c = (c + 1) % NQ;
            r.core_id  = core_id_t'(c);
            r.is_write = 1'($urandom % 2);
            r.addr     = $urandom;
            push_req(r);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((pending_count() != 0 || out_valid) && waited < DRAIN_TIMEOUT) begin
            @(posedge aclk);
            #2;
            waited++;
        end
        if (pending_count() != 0 || out_valid) report_error("requests did not drain in time");
    endtask

    task automatic begin_test();
        test_start_errors = error_count;
    endtask

    task automatic end_test(input string name);
        if (error_count == test_start_errors) begin
            pass_count++;
            $display("test %s passed", name);
        end else begin
            fail_count++;
            $display("test %s failed with %0d errors", name, error_count - test_start_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // egress ready and comparator
    ////////////////////////////////////////////////////////////////////////////

    // 0 stalled, 1 ready, 2 random
    always @(posedge aclk) begin
        #2;
        if (ready_mode == 0) out_ready = 1'b0;
        else if (ready_mode == 1) out_ready = 1'b1;
        else out_ready = 1'($urandom % 2);
    end

    // mid-cycle view of what the next rising edge will see
    always @(negedge aclk) begin : compare_proc
        int       pick;
        mem_req_t exp_req;
        if (arst_n) begin
            // a stalled output holds its value
            if (prev_stall) begin
                if (!out_valid) report_error("out_valid dropped while out was stalled");
                else if (out !== prev_out) report_mismatch("out", 64'(prev_out), 64'(out));
            end
            prev_stall = out_valid && !out_ready;
            prev_out   = out;
            // queue occupancy and output timing, not modelled for tdma
            if (m_policy != POLICY_TDMA) begin
                if (req_ready !== (mq_req[req.core_id].size() != DEPTH)) begin
                    report_mismatch("req_ready", 64'(mq_req[req.core_id].size() != DEPTH),
                                    64'(req_ready));
                end
                if (out_valid !== m_ov) report_mismatch("out_valid", 64'(m_ov), 64'(out_valid));
            end
            if (req_valid && !req_ready) saw_full = 1'b1;
            if (out_valid && out_ready) begin
                if (sent[out.core_id].size() == 0) begin
                    report_error("out carried a request that was not pending");
                end else begin
                    exp_req = sent[out.core_id].pop_front();
                    if (out !== exp_req) report_mismatch("out", 64'(exp_req), 64'(out));
                end
                if (m_policy != POLICY_TDMA && m_ov && out !== m_out) begin
                    report_mismatch("out", 64'(m_out), 64'(out));
                end
                if (m_policy == POLICY_TDMA && mq_req[out.core_id].size() != 0) begin
                    void'(mq_req[out.core_id].pop_front());
                    void'(mq_dl[out.core_id].pop_front());
                end
            end
            // output register loads when free or draining
            if (m_policy == POLICY_TDMA) begin
                m_ov = 1'b0;
            end else if (!m_ov || out_ready) begin
                pick = (m_policy == POLICY_EDF) ? predict_edf() : predict_fp();
                m_ov = (pick >= 0);
                if (pick >= 0) begin
                    m_out = mq_req[pick].pop_front();
                    void'(mq_dl[pick].pop_front());
                end
            end
            // acceptance, stamped with the local cycle count
            if (req_valid && req_ready) begin
                mq_req[req.core_id].push_back(req);
                mq_dl[req.core_id].push_back(tb_cycle + m_dl[req.core_id]);
                sent[req.core_id].push_back(req);
            end
            tb_cycle = tb_cycle + 32'd1;
        end
    end

    // ends a hung run
    initial begin : watchdog
        repeat (RESET_CYCLES + BUDGET_REGS + BUDGET_FP + BUDGET_EDF + BUDGET_TDMA +
                BUDGET_BP + BUDGET_MARGIN) @(posedge aclk);
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        void'($urandom(32'h9d2d));
        aclk = 1'b0;
        arst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        out_ready = 1'b0;
        apb = '0;
        ready_mode = 1;
        saw_full = 1'b0;
        m_policy = POLICY_FP;
        m_slot = 16'd1;
        for (int i = 0; i < NQ; i++) begin
            m_dl[i]   = '0;
            m_prio[i] = 4'(i);
        end
        m_ov = 1'b0;
        m_out = '0;
        tb_cycle = '0;
        prev_stall = 1'b0;
        prev_out = '0;
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        repeat (RESET_CYCLES) @(posedge aclk);
        #2;
        arst_n = 1'b1;

        // reset values, read back, refused accesses
        begin_test();
        if (out_valid !== 1'b0) report_mismatch("out_valid", 64'(0), 64'(out_valid));
        if (req_ready !== 1'b1) report_mismatch("req_ready", 64'(1), 64'(req_ready));
        if (apb_rsp.pslverr !== 1'b0) report_mismatch("pslverr", 64'(0), 64'(apb_rsp.pslverr));
        read_all_regs();
        apb_write(`MS_REG_MODE, 32'(POLICY_EDF));
        apb_write(`MS_REG_SLOT, 32'($urandom % 65536));
        for (int i = 0; i < NQ; i++) begin
            apb_write(`MS_REG_DL_BASE + 8'(4 * i), $urandom);
            apb_write(`MS_REG_PRIO_BASE + 8'(4 * i), 32'($urandom % 16));
        end
        read_all_regs();
        apb_write(8'h08, $urandom);
        apb_write(8'h30, $urandom);
        apb_write(`MS_REG_MODE, 32'd3);
        apb_read(8'h0c);
        read_all_regs();
        apb_write(`MS_REG_MODE, 32'(POLICY_FP));
        end_test("registers");

        // fixed priority, loaded behind a stalled output
        begin_test();
        ready_mode = 0;
        for (int i = 0; i < NQ; i++) begin
            apb_write(`MS_REG_DL_BASE + 8'(4 * i), 32'd0);
            apb_write(`MS_REG_PRIO_BASE + 8'(4 * i), 32'($urandom % 16));
        end
        fill_queues(24, 1'b1, 1'b0);
        ready_mode = 1;
        wait_drain();
        end_test("fixed priority");

        // earliest deadline first
        begin_test();
        ready_mode = 0;
        for (int i = 0; i < NQ; i++) begin
            apb_write(`MS_REG_DL_BASE + 8'(4 * i), 32'($urandom % 64));
        end
        apb_write(`MS_REG_MODE, 32'(POLICY_EDF));
        fill_queues(24, 1'b1, 1'b0);
        ready_mode = 1;
        wait_drain();
        end_test("earliest deadline first");

        // time-division slots, fifo order and completeness only
        begin_test();
        ready_mode = 0;
        apb_write(`MS_REG_SLOT, 32'(1 + $urandom % 3));
        apb_write(`MS_REG_MODE, 32'(POLICY_TDMA));
        fill_queues(24, 1'b1, 1'b0);
        ready_mode = 1;
        wait_drain();
        end_test("time-division");

        // random ready, core 0 starved so it fills
        begin_test();
        saw_full = 1'b0;
        apb_write(`MS_REG_MODE, 32'(POLICY_FP));
        apb_write(`MS_REG_PRIO_BASE, 32'd15);
        ready_mode = 2;
        fill_queues(48, 1'b0, 1'b1);
        wait_drain();
        ready_mode = 1;
        if (!saw_full) report_error("no queue became full during the back-pressure test");
        end_test("back-pressure");

        $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+hdl
hdl/mem_sched_pkg.sv
hdl/sched_config_regs.sv
hdl/request_queue.sv
hdl/queue_selector.sv
hdl/mem_sched_top.sv
verif/mem_sched_tb.sv

//--- run.sh
#!/bin/sh
# build and run the scheduler testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module mem_sched_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vmem_sched_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# pass only on the exact pass line
if printf '%s\n' "$sim_out" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "pass message not found"
exit 1
